/* common/i2c_pkg.sv */
package i2c_pkg;

    // ==================================================
    // Bus-level types
    // ==================================================

    // 7-bit target address, without the R/W bit
    typedef logic [6:0] i2c_addr_t;

    // One bit-level command for the bit engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } bit_cmd_e;

    // Open-drain enables, 1 pulls the line low
    typedef struct packed {
        logic scl_oe;
        logic sda_oe;
    } i2c_lines_t;

    // ==================================================
    // Probe range, reserved addresses excluded
    // ==================================================
    localparam i2c_addr_t ADDR_FIRST = 7'h08;
    localparam i2c_addr_t ADDR_LAST  = 7'h77;

endpackage

/* common/report_pkg.sv */
package report_pkg;

    // ==================================================
    // Report characters
    // ==================================================

    // One 8N1 character
    typedef logic [7:0] uart_byte_t;

    // Separators
    localparam uart_byte_t CHR_SPACE = 8'h20;
    localparam uart_byte_t CHR_CR    = 8'h0D;
    localparam uart_byte_t CHR_LF    = 8'h0A;

    // Bases for hex digits, upper case
    localparam uart_byte_t CHR_ZERO    = 8'h30;
    localparam uart_byte_t CHR_UPPER_A = 8'h41;

endpackage

/* filelist.f */
common/i2c_pkg.sv
common/report_pkg.sv
i2c/i2c_bit_engine.sv
i2c/i2c_probe.sv
verilog/uart_tx.sv
verilog/i2c_scan.sv
verilog/scan_top.sv
test/i2c_target_model.sv
test/scan_tb.sv

/* i2c/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int I2C_PRESCALER = 250
) (
    input  logic                 clk_g,
    input  logic                 rst,
    input  logic                 cmd_valid_i,
    input  i2c_pkg::bit_cmd_e    cmd_i,
    input  logic                 wbit_i,
    input  logic                 sda_i,
    output logic                 cmd_done_o,
    output logic                 rbit_o,
    output i2c_pkg::i2c_lines_t  lines_o
);

    // Prescaler counts one quarter bit
    localparam int PW = (I2C_PRESCALER > 1) ? $clog2(I2C_PRESCALER) : 1;
    localparam logic [PW-1:0] PRE_MAX = PW'(I2C_PRESCALER - 1);

    // Idle plus four quarter-bit phases
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PH0,
        ST_PH1,
        ST_PH2,
        ST_PH3
    } state_e;

    state_e              state;
    state_e              ph_next;
    logic [PW-1:0]       pre_cnt;
    i2c_pkg::bit_cmd_e   cmd_q;
    logic                wbit_q;
    logic                rbit_q;
    logic                done_q;
    i2c_pkg::i2c_lines_t lines_q;

    // ==================================================
    // Line levels per command and phase
    // ==================================================
    function automatic i2c_pkg::i2c_lines_t phase_lines(
        input i2c_pkg::bit_cmd_e cmd,
        input logic              wbit,
        input state_e            ph
    );
        i2c_pkg::i2c_lines_t l;
        l = '0;
        case (cmd)
            // SDA falls in PH2 with SCL still high
            i2c_pkg::CMD_START: begin
                l.sda_oe = (ph == ST_PH2) || (ph == ST_PH3);
                l.scl_oe = (ph == ST_PH3);
            end
            // SDA rises in PH2 with SCL high
            i2c_pkg::CMD_STOP: begin
                l.sda_oe = (ph == ST_PH0) || (ph == ST_PH1);
                l.scl_oe = (ph == ST_PH0);
            end
            // Data held for the whole bit, SCL high in PH1 and PH2
            i2c_pkg::CMD_WRITE: begin
                l.sda_oe = ~wbit;
                l.scl_oe = (ph == ST_PH0) || (ph == ST_PH3);
            end
            // Read leaves SDA to the target
            default: begin
                l.sda_oe = 1'b0;
                l.scl_oe = (ph == ST_PH0) || (ph == ST_PH3);
            end
        endcase
        return l;
    endfunction

    // Phase order
    always_comb begin
        case (state)
            ST_PH0:  ph_next = ST_PH1;
            ST_PH1:  ph_next = ST_PH2;
            ST_PH2:  ph_next = ST_PH3;
            default: ph_next = ST_IDLE;
        endcase
    end

    // ==================================================
    // Phase sequencer
    // ==================================================
    always_ff @(posedge clk_g) begin
        done_q <= 1'b0;
        if (rst) begin
            state   <= ST_IDLE;
            pre_cnt <= '0;
            lines_q <= '0;
        end else if (state == ST_IDLE) begin
            // Accept, first phase levels go out at once
            if (cmd_valid_i) begin
                state   <= ST_PH0;
                pre_cnt <= '0;
                lines_q <= phase_lines(cmd_i, wbit_i, ST_PH0);
            end
        end else if (pre_cnt == PRE_MAX) begin
            pre_cnt <= '0;
            if (state == ST_PH3) begin
                // Lines hold their last levels until the next command
                state  <= ST_IDLE;
                done_q <= 1'b1;
            end else begin
                state   <= ph_next;
                lines_q <= phase_lines(cmd_q, wbit_q, ph_next);
            end
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Command payload, latched on accept
    always_ff @(posedge clk_g) begin
        if (state == ST_IDLE && cmd_valid_i) begin
            cmd_q  <= cmd_i;
            wbit_q <= wbit_i;
        end
    end

    // Sample at the middle of SCL high
    always_ff @(posedge clk_g) begin
        if (state == ST_PH1 && pre_cnt == PRE_MAX && cmd_q == i2c_pkg::CMD_READ) begin
            rbit_q <= sda_i;
        end
    end

    assign cmd_done_o = done_q;
    assign rbit_o     = rbit_q;
    assign lines_o    = lines_q;

    // Caller must wait for cmd_done
    a_no_overlap: assert property (@(posedge clk_g) disable iff (rst)
        cmd_valid_i |-> state == ST_IDLE);

endmodule

/* i2c/i2c_probe.sv */
`timescale 1ns/1ps

module i2c_probe #(
    parameter int I2C_PRESCALER = 250
) (
    input  logic                 clk_g,
    input  logic                 rst,
    input  logic                 probe_start_i,
    input  i2c_pkg::i2c_addr_t   addr_i,
    output logic                 probe_done_o,
    output logic                 ack_o,
    output i2c_pkg::i2c_lines_t  lines_o,
    input  logic                 scl_i,
    input  logic                 sda_i
);

    typedef enum logic [2:0] {
        PS_IDLE,
        PS_START,
        PS_ADDR,
        PS_ACK,
        PS_STOP
    } state_e;

    state_e            state;
    logic [2:0]        bit_cnt;
    logic [7:0]        shreg;
    logic              cmd_valid;
    i2c_pkg::bit_cmd_e cmd;
    logic              cmd_done;
    logic              rbit;
    logic              ack_q;
    logic              done_q;

    // ==================================================
    // Command sequencer
    // ==================================================
    always_ff @(posedge clk_g) begin
        cmd_valid <= 1'b0;
        done_q    <= 1'b0;
        if (rst) begin
            state   <= PS_IDLE;
            cmd     <= i2c_pkg::CMD_START;
            bit_cnt <= '0;
            ack_q   <= 1'b0;
        end else begin
            case (state)
                PS_IDLE: if (probe_start_i) begin
                    cmd       <= i2c_pkg::CMD_START;
                    cmd_valid <= 1'b1;
                    state     <= PS_START;
                end
                // Eight WRITEs, address MSB first then R/W = 0
                PS_START: if (cmd_done) begin
                    cmd       <= i2c_pkg::CMD_WRITE;
                    cmd_valid <= 1'b1;
                    bit_cnt   <= '0;
                    state     <= PS_ADDR;
                end
                PS_ADDR: if (cmd_done) begin
                    cmd_valid <= 1'b1;
                    if (bit_cnt == 3'd7) begin
                        cmd   <= i2c_pkg::CMD_READ;
                        state <= PS_ACK;
                    end else begin
                        cmd     <= i2c_pkg::CMD_WRITE;
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                end
                // Low SDA in the ninth clock is an ACK
                PS_ACK: if (cmd_done) begin
                    ack_q     <= ~rbit;
                    cmd       <= i2c_pkg::CMD_STOP;
                    cmd_valid <= 1'b1;
                    state     <= PS_STOP;
                end
                default: if (cmd_done) begin
                    done_q <= 1'b1;
                    state  <= PS_IDLE;
                end
            endcase
        end
    end

    // Address byte, shifted once per finished bit
    always_ff @(posedge clk_g) begin
        if (state == PS_IDLE && probe_start_i) begin
            shreg <= {addr_i, 1'b0};
        end else if (state == PS_ADDR && cmd_done) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    i2c_bit_engine #(
        .I2C_PRESCALER (I2C_PRESCALER)
    ) u_engine (
        .clk_g       (clk_g),
        .rst         (rst),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .wbit_i      (shreg[7]),
        .sda_i       (sda_i),
        .cmd_done_o  (cmd_done),
        .rbit_o      (rbit),
        .lines_o     (lines_o)
    );

    assign probe_done_o = done_q;
    assign ack_o        = ack_q;

    // Resolved SCL must follow our own pull-down
    a_scl_follows: assert property (@(posedge clk_g) disable iff (rst)
        lines_o.scl_oe |-> !scl_i);

endmodule

/* test/i2c_target_model.sv */
`timescale 1ns/1ps

module i2c_target_model (
    input  logic         scl_i,
    input  logic         sda_i,
    input  logic [127:0] ack_map_i,
    output logic         sda_o,
    output int           start_cnt_o,
    output int           stop_cnt_o
);

    logic [7:0] shreg;
    // 15 marks no open transfer
    logic [3:0] bit_cnt;

    initial begin
        sda_o       = 1'b1;
        shreg       = '0;
        bit_cnt     = 4'd15;
        start_cnt_o = 0;
        stop_cnt_o  = 0;
    end

    // START, SDA falls while SCL is high
    always @(negedge sda_i) begin
        if (scl_i === 1'b1) begin
            start_cnt_o = start_cnt_o + 1;
            bit_cnt     = 4'd0;
        end
    end

    // STOP, SDA rises while SCL is high
    always @(posedge sda_i) begin
        if (scl_i === 1'b1 && bit_cnt != 4'd15) begin
            stop_cnt_o = stop_cnt_o + 1;
            bit_cnt    = 4'd15;
            sda_o      = 1'b1;
        end
    end

    // Address and R/W bit, MSB first
    always @(posedge scl_i) begin
        if (bit_cnt < 4'd9) begin
            if (bit_cnt < 4'd8) begin
                shreg = {shreg[6:0], sda_i};
            end
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    // ACK driven through the ninth clock, only for a write to a listed address
    always @(negedge scl_i) begin
        if (bit_cnt == 4'd8 && shreg[0] == 1'b0 && ack_map_i[shreg[7:1]]) begin
            sda_o = 1'b0;
        end else if (bit_cnt == 4'd9) begin
            sda_o = 1'b1;
        end
    end

endmodule

/* test/scan_tb.sv */
`timescale 1ns/1ps

module scan_tb;

    localparam int I2C_PRESCALER  = 4;
    localparam int UART_PRESCALER = 8;
    // Longer than one full scan with a report
    localparam int SCAN_TIMEOUT   = 40000;
    localparam int PROBE_COUNT    = int'(i2c_pkg::ADDR_LAST) - int'(i2c_pkg::ADDR_FIRST) + 1;

    logic                   clk_g;
    logic                   rst;
    logic                   trg;
    logic                   trg_en;
    logic                   scl;
    logic                   sda;
    logic                   tgt_sda;
    logic [127:0]           ack_map;
    i2c_pkg::i2c_lines_t    lines;
    logic                   tx;
    logic                   busy;
    int                     start_cnt;
    int                     stop_cnt;
    int                     errors;
    int                     checks;
    report_pkg::uart_byte_t rx_q[$];
    report_pkg::uart_byte_t exp_q[$];

    initial clk_g = 1'b0;
    always #50 clk_g = ~clk_g;

    // Wired pull-up, any driver pulls low
    assign scl = ~lines.scl_oe;
    assign sda = ~lines.sda_oe & tgt_sda;

    scan_top #(
        .I2C_PRESCALER  (I2C_PRESCALER),
        .UART_PRESCALER (UART_PRESCALER)
    ) DUT (
        .clk_g    (clk_g),
        .rst      (rst),
        .trg_i    (trg),
        .trg_en_i (trg_en),
        .scl_i    (scl),
        .sda_i    (sda),
        .lines_o  (lines),
        .tx_o     (tx),
        .busy_o   (busy)
    );

    i2c_target_model u_target (
        .scl_i       (scl),
        .sda_i       (sda),
        .ack_map_i   (ack_map),
        .sda_o       (tgt_sda),
        .start_cnt_o (start_cnt),
        .stop_cnt_o  (stop_cnt)
    );

    // ==================================================
    // Helpers
    // ==================================================
    task automatic tick();
        @(posedge clk_g);
        #1;
    endtask

    task automatic check_int(input string name, input logic [31:0] got, input int expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    // Upper-case ASCII digit
    function automatic report_pkg::uart_byte_t hex_digit(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits.getc(int'(nib));
    endfunction

    // Two hex digits and a space per ACK, then CR LF
    task automatic build_expected(input logic [127:0] map);
        logic [7:0] a;
        exp_q.delete();
        for (int i = int'(i2c_pkg::ADDR_FIRST); i <= int'(i2c_pkg::ADDR_LAST); i++) begin
            a = 8'(i);
            if (map[i]) begin
                exp_q.push_back(hex_digit(a[7:4]));
                exp_q.push_back(hex_digit(a[3:0]));
                exp_q.push_back(report_pkg::CHR_SPACE);
            end
        end
        exp_q.push_back(report_pkg::CHR_CR);
        exp_q.push_back(report_pkg::CHR_LF);
    endtask

    // Called half a clock into the start bit, samples near mid-bit
    task automatic receive_byte();
        report_pkg::uart_byte_t data;
        repeat (UART_PRESCALER / 2 - 1) @(negedge clk_g);
        if (tx !== 1'b0) begin
            errors++;
            $display("UART start bit too short at %0t", $time);
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (UART_PRESCALER) @(negedge clk_g);
            data[i] = tx;
        end
        repeat (UART_PRESCALER) @(negedge clk_g);
        if (tx !== 1'b1) begin
            errors++;
            $display("UART stop bit missing at %0t", $time);
        end
        rx_q.push_back(data);
    endtask

    // UART capture
    initial begin
        forever begin
            @(negedge clk_g);
            if (tx === 1'b0) begin
                receive_byte();
            end
        end
    end

    task automatic pulse_trigger();
        tick();
        trg = 1'b1;
        tick();
        trg = 1'b0;
    endtask

    task automatic wait_busy(input logic level, input int limit, output bit ok);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            tick();
            n++;
        end
        ok = (busy === level);
        if (!ok) begin
            errors++;
            $display("Timeout waiting for busy_o to become %0b", level);
        end
    endtask

    task automatic compare_report(input string tag);
        checks++;
        if (rx_q.size() != exp_q.size()) begin
            errors++;
            $display("FAIL t=%0t %s report length: got %0d expected %0d",
                     $time, tag, rx_q.size(), exp_q.size());
        end else begin
            for (int i = 0; i < exp_q.size(); i++) begin
                if (rx_q[i] != exp_q[i]) begin
                    errors++;
                    $display("FAIL t=%0t %s tx_o byte %0d: got %h expected %h",
                             $time, tag, i, rx_q[i], exp_q[i]);
                end
            end
        end
    endtask

    // One scan, optional second trigger while busy
    task automatic run_scan(input logic [127:0] map, input string tag, input bit retrig);
        int  starts0;
        int  stops0;
        bit  ok;
        tick();
        ack_map = map;
        build_expected(map);
        rx_q.delete();
        starts0 = start_cnt;
        stops0  = stop_cnt;
        pulse_trigger();
        wait_busy(1'b1, 10, ok);
        if (ok && retrig) begin
            repeat (20) tick();
            pulse_trigger();
        end
        if (ok) begin
            wait_busy(1'b0, SCAN_TIMEOUT, ok);
        end
        compare_report(tag);
        check_int({tag, " START count"}, start_cnt - starts0, PROBE_COUNT);
        check_int({tag, " STOP count"}, stop_cnt - stops0, PROBE_COUNT);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_state();
        check_int("busy_o", busy, 0);
        check_int("tx_o", tx, 1);
        check_int("lines_o.scl_oe", lines.scl_oe, 0);
        check_int("lines_o.sda_oe", lines.sda_oe, 0);
    endtask

    task automatic test_three_targets();
        logic [127:0] m;
        m        = '0;
        m[7'h1E] = 1'b1;
        m[7'h50] = 1'b1;
        m[7'h68] = 1'b1;
        run_scan(m, "three targets", 1'b0);
    endtask

    task automatic test_no_targets();
        run_scan('0, "no targets", 1'b0);
    endtask

    task automatic test_trigger_disabled();
        bit seen;
        seen = 1'b0;
        rx_q.delete();
        trg_en = 1'b0;
        pulse_trigger();
        for (int n = 0; n < SCAN_TIMEOUT && !seen; n++) begin
            tick();
            if (busy !== 1'b0) begin
                seen = 1'b1;
                errors++;
                $display("FAIL t=%0t busy_o: got %b expected 0", $time, busy);
            end else if (rx_q.size() != 0) begin
                seen = 1'b1;
                errors++;
                $display("UART byte sent although the trigger was disabled");
            end
        end
        checks++;
        trg_en = 1'b1;
    endtask

    task automatic test_retrigger();
        logic [127:0] m;
        int           n;
        m        = '0;
        m[7'h3C] = 1'b1;
        run_scan(m, "retrigger", 1'b1);
        // Dropped trigger must not start a second scan
        n = 0;
        while (busy === 1'b0 && n < 500) begin
            tick();
            n++;
        end
        check_int("busy_o after report", busy, 0);
        check_int("report byte count", rx_q.size(), exp_q.size());
    endtask

    task automatic test_range_edges();
        logic [127:0] m;
        m                      = '0;
        m[i2c_pkg::ADDR_FIRST] = 1'b1;
        m[i2c_pkg::ADDR_LAST]  = 1'b1;
        run_scan(m, "range edges", 1'b0);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        trg     = 1'b0;
        trg_en  = 1'b1;
        ack_map = '0;
        repeat (8) tick();
        rst = 1'b0;
        tick();
        test_reset_state();
        test_three_targets();
        test_no_targets();
        test_trigger_disabled();
        test_retrigger();
        test_range_edges();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/i2c_scan.sv */
`timescale 1ns/1ps

module i2c_scan #(
    parameter int I2C_PRESCALER  = 250,
    parameter int UART_PRESCALER = 868
) (
    input  logic                 clk_g,
    input  logic                 rst,
    input  logic                 start_i,
    input  logic                 scl_i,
    input  logic                 sda_i,
    output logic                 busy_o,
    output i2c_pkg::i2c_lines_t  lines_o,
    output logic                 tx_o
);

    typedef enum logic [3:0] {
        SC_IDLE, SC_PROBE, SC_WAIT, SC_HEX_HI, SC_HEX_LO,
        SC_SPACE, SC_NEXT, SC_CR, SC_LF, SC_DRAIN
    } state_e;

    state_e                 state;
    i2c_pkg::i2c_addr_t     addr;
    logic                   probe_start;
    logic                   probe_done;
    logic                   ack;
    logic                   tx_start;
    report_pkg::uart_byte_t tx_byte;
    logic                   tx_busy;
    logic                   tx_ready;

    // Nibble to upper-case ASCII
    function automatic report_pkg::uart_byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return report_pkg::CHR_ZERO + {4'd0, nib};
        end
        return report_pkg::CHR_UPPER_A + {4'd0, nib} - 8'd10;
    endfunction

    // Pulse still in flight counts as busy
    assign tx_ready = !tx_busy && !tx_start;

    // ==================================================
    // Scan FSM
    // ==================================================
    always_ff @(posedge clk_g) begin
        probe_start <= 1'b0;
        tx_start    <= 1'b0;
        if (rst) begin
            state <= SC_IDLE;
            addr  <= i2c_pkg::ADDR_FIRST;
        end else begin
            case (state)
                SC_IDLE: if (start_i) begin
                    addr  <= i2c_pkg::ADDR_FIRST;
                    state <= SC_PROBE;
                end
                SC_PROBE: begin
                    probe_start <= 1'b1;
                    state       <= SC_WAIT;
                end
                // ACK means queue hex and space
                SC_WAIT: if (probe_done) begin
                    state <= ack ? SC_HEX_HI : SC_NEXT;
                end
                SC_HEX_HI: if (tx_ready) begin
                    tx_start <= 1'b1;
                    tx_byte  <= hex_char({1'b0, addr[6:4]});
                    state    <= SC_HEX_LO;
                end
                SC_HEX_LO: if (tx_ready) begin
                    tx_start <= 1'b1;
                    tx_byte  <= hex_char(addr[3:0]);
                    state    <= SC_SPACE;
                end
                SC_SPACE: if (tx_ready) begin
                    tx_start <= 1'b1;
                    tx_byte  <= report_pkg::CHR_SPACE;
                    state    <= SC_NEXT;
                end
                SC_NEXT: begin
                    if (addr == i2c_pkg::ADDR_LAST) begin
                        state <= SC_CR;
                    end else begin
                        addr  <= addr + 7'd1;
                        state <= SC_PROBE;
                    end
                end
                // Line end
                SC_CR: if (tx_ready) begin
                    tx_start <= 1'b1;
                    tx_byte  <= report_pkg::CHR_CR;
                    state    <= SC_LF;
                end
                SC_LF: if (tx_ready) begin
                    tx_start <= 1'b1;
                    tx_byte  <= report_pkg::CHR_LF;
                    state    <= SC_DRAIN;
                end
                // Busy holds until LF stop bit is out
                default: if (tx_ready) begin
                    state <= SC_IDLE;
                end
            endcase
        end
    end

    assign busy_o = (state != SC_IDLE);

    i2c_probe #(
        .I2C_PRESCALER (I2C_PRESCALER)
    ) u_probe (
        .clk_g         (clk_g),
        .rst           (rst),
        .probe_start_i (probe_start),
        .addr_i        (addr),
        .probe_done_o  (probe_done),
        .ack_o         (ack),
        .lines_o       (lines_o),
        .scl_i         (scl_i),
        .sda_i         (sda_i)
    );

    uart_tx #(
        .UART_PRESCALER (UART_PRESCALER)
    ) u_uart (
        .clk_g      (clk_g),
        .rst        (rst),
        .tx_start_i (tx_start),
        .data_i     (tx_byte),
        .tx_busy_o  (tx_busy),
        .tx_o       (tx_o)
    );

endmodule

/* verilog/scan_top.sv */
`timescale 1ns/1ps

module scan_top #(
    // 100 kHz SCL at 100 MHz
    parameter int I2C_PRESCALER  = 250,
    // 115200 baud at 100 MHz
    parameter int UART_PRESCALER = 868
) (
    input  logic                 clk_g,
    input  logic                 rst,
    input  logic                 trg_i,
    input  logic                 trg_en_i,
    input  logic                 scl_i,
    input  logic                 sda_i,
    output i2c_pkg::i2c_lines_t  lines_o,
    output logic                 tx_o,
    output logic                 busy_o
);

    logic scan_start;

    // Trigger gate, drops strobes during a scan
    assign scan_start = trg_i & trg_en_i & ~busy_o;

    i2c_scan #(
        .I2C_PRESCALER  (I2C_PRESCALER),
        .UART_PRESCALER (UART_PRESCALER)
    ) u_scan (
        .clk_g   (clk_g),
        .rst     (rst),
        .start_i (scan_start),
        .scl_i   (scl_i),
        .sda_i   (sda_i),
        .busy_o  (busy_o),
        .lines_o (lines_o),
        .tx_o    (tx_o)
    );

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int UART_PRESCALER = 868
) (
    input  logic                   clk_g,
    input  logic                   rst,
    input  logic                   tx_start_i,
    input  report_pkg::uart_byte_t data_i,
    output logic                   tx_busy_o,
    output logic                   tx_o
);

    localparam int PW = (UART_PRESCALER > 1) ? $clog2(UART_PRESCALER) : 1;
    localparam logic [PW-1:0] PRE_MAX = PW'(UART_PRESCALER - 1);

    logic [PW-1:0] pre_cnt;
    logic [3:0]    bit_cnt;
    logic [9:0]    shreg;
    logic          busy_q;

    // ==================================================
    // Frame shifter, stop/data/start with LSB out first
    // ==================================================
    always_ff @(posedge clk_g) begin
        if (rst) begin
            // All ones keeps the line idle high
            shreg   <= '1;
            busy_q  <= 1'b0;
            pre_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy_q) begin
            if (tx_start_i) begin
                shreg   <= {1'b1, data_i, 1'b0};
                busy_q  <= 1'b1;
                pre_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (pre_cnt == PRE_MAX) begin
            pre_cnt <= '0;
            // Ones fill in behind, line stays high after stop
            shreg <= {1'b1, shreg[9:1]};
            if (bit_cnt == 4'd9) begin
                busy_q <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    assign tx_o      = shreg[0];
    assign tx_busy_o = busy_q;

    // Scanner must wait out the frame
    a_no_restart: assert property (@(posedge clk_g) disable iff (rst)
        tx_start_i |-> !tx_busy_o);

endmodule
